// ==== logic/frontend_defines.svh ====
// sizes are fixed by the address map; FE_BTB_IDX_W and FE_TAG_W must cover bits above the block
`ifndef FRONTEND_DEFINES_SVH
`define FRONTEND_DEFINES_SVH

`define FE_ADDR_W 43 // fetch address bits
`define FE_BLOCK_BITS 4 // 16-byte fetch block
`define FE_BTB_IDX_W 9 // btb index, ip[12:4]
`define FE_GHR_W 8
`define FE_PT_IDX_W 8 // predictor table index
`define FE_RAS_DEPTH 8
`define FE_SLOTS 2 // branch slots per block

// tag is whatever sits above the btb index
`define FE_TAG_W (`FE_ADDR_W - `FE_BTB_IDX_W - `FE_BLOCK_BITS)

`endif

// ==== logic/fetch_pkg.sv ====
// predictor index functions assume FE_GHR_W >= 8 and FE_PT_IDX_W == 8; targets need not be aligned
`include "frontend_defines.svh"

package fetch_pkg;

  typedef logic [`FE_ADDR_W-1:0] addr_t;
  typedef logic [`FE_GHR_W-1:0] ghr_t;
  typedef logic [`FE_BTB_IDX_W-1:0] btb_idx_t;
  typedef logic [`FE_TAG_W-1:0] btb_tag_t;
  typedef logic [`FE_PT_IDX_W-1:0] pt_idx_t;
  typedef logic [$clog2(`FE_SLOTS)-1:0] slot_t;

  typedef enum logic [1:0] {br_cond, br_jump, br_call, br_ret} br_kind_t;
  typedef enum logic [1:0] {tbl_a, tbl_b, tbl_c} tbl_sel_t;

  typedef struct packed {
    logic valid;
    btb_tag_t tag;
    addr_t target;
    br_kind_t kind;
  } btb_entry_t;

  typedef btb_entry_t [`FE_SLOTS-1:0] btb_set_t;
  typedef logic [`FE_SLOTS-1:0] pt_bits_t; // one direction bit per slot

  typedef struct packed {
    logic taken;
    slot_t slot;
    br_kind_t kind;
    addr_t target;
  } fetch_pred_t;

  typedef struct packed {
    logic valid;
    addr_t ip;
    logic taken;
  } fetch_out_t;

  function automatic addr_t blk_align(input addr_t ip);
    return ip & ~addr_t'((1 << `FE_BLOCK_BITS) - 1);
  endfunction

  function automatic addr_t next_block(input addr_t ip);
    return blk_align(ip) + addr_t'(1 << `FE_BLOCK_BITS);
  endfunction

  function automatic btb_idx_t btb_index(input addr_t ip);
    return ip[`FE_BLOCK_BITS +: `FE_BTB_IDX_W];
  endfunction

  function automatic btb_tag_t btb_tag(input addr_t ip);
    return ip[`FE_ADDR_W-1 -: `FE_TAG_W];
  endfunction

  // A mixes short history, C is history only
  function automatic pt_idx_t pt_index(input tbl_sel_t sel, input addr_t ip, input ghr_t ghr);
    case (sel)
      tbl_a: return {ip[9:4], ghr[1:0]};
      tbl_b: return {ip[7:4], ghr[3:0]};
      default: return ghr[7:0];
    endcase
  endfunction

endpackage

// ==== logic/retire_pkg.sv ====
// a retire strobe always means a resolved misprediction; ghr is the history at fetch time
package retire_pkg;

  typedef struct packed {
    logic valid;
    fetch_pkg::addr_t src_ip;
    fetch_pkg::addr_t target;
    fetch_pkg::slot_t slot;
    fetch_pkg::br_kind_t kind;
    logic taken;
    fetch_pkg::ghr_t ghr;
  } retire_t;

  typedef struct packed {
    logic valid;
    fetch_pkg::addr_t ip;
    fetch_pkg::ghr_t ghr;
  } redirect_t;

  typedef struct packed {
    logic we;
    fetch_pkg::btb_idx_t index;
    fetch_pkg::slot_t slot;
    fetch_pkg::btb_entry_t entry;
  } btb_update_t;

  typedef struct packed {
    logic en;
    fetch_pkg::tbl_sel_t sel; // 0 = A, 1 = B, 2 = C
    fetch_pkg::pt_idx_t index;
    fetch_pkg::slot_t slot;
  } pt_update_t;

endpackage

// ==== logic/entry_ram.sv ====
// reads are asynchronous and see a write from the previous edge; reset clears every entry
`timescale 1ns/1ps

module entry_ram #(
  parameter type entry_t = logic,
  parameter int depth = 16
) (
  input logic clk,
  input logic rst,
  input logic [$clog2(depth)-1:0] rd_idx_a, // fetch side
  input logic [$clog2(depth)-1:0] rd_idx_b, // update read-modify-write
  output entry_t rd_data_a,
  output entry_t rd_data_b,
  input logic we,
  input logic [$clog2(depth)-1:0] wr_idx,
  input entry_t wr_data
);

  entry_t mem [depth];

  assign rd_data_a = mem[rd_idx_a];
  assign rd_data_b = mem[rd_idx_b];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < depth; i++) begin
        mem[i] <= '0;
      end
    end else if (we) begin
      mem[wr_idx] <= wr_data;
    end
  end

endmodule

// ==== logic/retire_intake.sv ====
// one correction per cycle at most; commands are valid one edge after the retire strobe
`timescale 1ns/1ps
`include "frontend_defines.svh"

module retire_intake (
  input logic clk,
  input logic rst,
  input retire_pkg::retire_t retire,
  output retire_pkg::redirect_t redirect,
  output retire_pkg::btb_update_t btb_upd,
  output retire_pkg::pt_update_t pt_upd
);

  import fetch_pkg::*;
  import retire_pkg::*;

  retire_t ret_q;
  tbl_sel_t sel_q;
  logic cond_upd;

  always_ff @(posedge clk) begin
    ret_q <= retire;
    if (rst) begin
      ret_q.valid <= 1'b0;
    end
  end

  assign cond_upd = ret_q.valid && ret_q.kind == br_cond;

  // A, B, C, A ...
  always_ff @(posedge clk) begin
    if (rst) begin
      sel_q <= tbl_a;
    end else if (cond_upd) begin
      case (sel_q)
        tbl_a: sel_q <= tbl_b;
        tbl_b: sel_q <= tbl_c;
        default: sel_q <= tbl_a;
      endcase
    end
  end

  always_comb begin
    redirect.valid = ret_q.valid;
    redirect.ip = ret_q.taken ? ret_q.target : next_block(ret_q.src_ip);
    redirect.ghr = {ret_q.ghr[`FE_GHR_W-2:0], ret_q.taken}; // restored history

    btb_upd.we = ret_q.valid;
    btb_upd.index = btb_index(ret_q.src_ip);
    btb_upd.slot = ret_q.slot;
    btb_upd.entry.valid = 1'b1;
    btb_upd.entry.tag = btb_tag(ret_q.src_ip);
    btb_upd.entry.target = ret_q.target;
    btb_upd.entry.kind = ret_q.kind;

    // only conditional branches touch the direction tables
    pt_upd.en = cond_upd;
    pt_upd.sel = sel_q;
    pt_upd.index = pt_index(sel_q, ret_q.src_ip, ret_q.ghr);
    pt_upd.slot = ret_q.slot;
  end

endmodule

// ==== logic/branch_predict.sv ====
// prediction is combinational from fetch_ip; updates land on the next edge and are seen at once
`timescale 1ns/1ps
`include "frontend_defines.svh"

module branch_predict (
  input logic clk,
  input logic rst,
  input fetch_pkg::addr_t fetch_ip,
  input fetch_pkg::ghr_t fetch_ghr,
  input retire_pkg::btb_update_t btb_upd,
  input retire_pkg::pt_update_t pt_upd,
  output fetch_pkg::fetch_pred_t pred
);

  import fetch_pkg::*;
  import retire_pkg::*;

  btb_set_t btb_rd_a;
  btb_set_t btb_rd_b;
  btb_set_t btb_wr;
  pt_bits_t pt_rd_a [3];
  pt_bits_t pt_rd_b [3];
  pt_idx_t pt_fetch_idx [3];
  logic [2:0] pt_we;
  pt_bits_t dir;
  logic [`FE_SLOTS-1:0] slot_hit;
  logic [`FE_SLOTS-1:0] slot_taken;

  entry_ram #(
    .entry_t(btb_set_t),
    .depth(1 << `FE_BTB_IDX_W)
  ) btb_i (
    .clk(clk),
    .rst(rst),
    .rd_idx_a(btb_index(fetch_ip)),
    .rd_idx_b(btb_upd.index),
    .rd_data_a(btb_rd_a),
    .rd_data_b(btb_rd_b),
    .we(btb_upd.we),
    .wr_idx(btb_upd.index),
    .wr_data(btb_wr)
  );

  // replace one slot, keep the other
  always_comb begin
    btb_wr = btb_rd_b;
    btb_wr[btb_upd.slot] = btb_upd.entry;
  end

  for (genvar t = 0; t < 3; t++) begin : g_pt
    assign pt_fetch_idx[t] = pt_index(tbl_sel_t'(t), fetch_ip, fetch_ghr);
    assign pt_we[t] = pt_upd.en && pt_upd.sel == tbl_sel_t'(t);

    entry_ram #(
      .entry_t(pt_bits_t),
      .depth(1 << `FE_PT_IDX_W)
    ) pt_i (
      .clk(clk),
      .rst(rst),
      .rd_idx_a(pt_fetch_idx[t]),
      .rd_idx_b(pt_upd.index),
      .rd_data_a(pt_rd_a[t]),
      .rd_data_b(pt_rd_b[t]),
      .we(pt_we[t]),
      .wr_idx(pt_upd.index),
      .wr_data(pt_rd_b[t] ^ (pt_bits_t'(1) << pt_upd.slot)) // flip one bit
    );
  end

  assign dir = pt_rd_a[0] ^ pt_rd_a[1] ^ pt_rd_a[2];

  always_comb begin
    pred = '0;
    for (int s = `FE_SLOTS - 1; s >= 0; s--) begin // lowest slot written last, so it wins
      slot_hit[s] = btb_rd_a[s].valid && btb_rd_a[s].tag == btb_tag(fetch_ip);
      slot_taken[s] = slot_hit[s] && (btb_rd_a[s].kind != br_cond || dir[s]);
      if (slot_taken[s]) begin
        pred.taken = 1'b1;
        pred.slot = slot_t'(s);
        pred.kind = btb_rd_a[s].kind;
        pred.target = btb_rd_a[s].target;
      end
    end
  end

endmodule

// ==== logic/return_stack.sv ====
// no overflow or underflow detection; the pointer wraps and old entries are overwritten
`timescale 1ns/1ps
`include "frontend_defines.svh"

module return_stack (
  input logic clk,
  input logic rst,
  input logic push,
  input logic pop,
  input fetch_pkg::addr_t push_addr,
  output fetch_pkg::addr_t top
);

  import fetch_pkg::*;

  localparam int ptr_w = $clog2(`FE_RAS_DEPTH);

  addr_t mem [`FE_RAS_DEPTH];
  logic [ptr_w-1:0] ptr_q; // next free entry
  logic [ptr_w-1:0] top_idx;

  assign top_idx = ptr_q - 1'b1;
  assign top = mem[top_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr_q <= '0;
      for (int i = 0; i < `FE_RAS_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (push) begin
      mem[ptr_q] <= push_addr;
      ptr_q <= ptr_q + 1'b1;
    end else if (pop) begin
      ptr_q <= top_idx;
    end
  end

endmodule

// ==== logic/fetch_seq.sv ====
// init_ip is held for one cycle after reset; a redirect overrides prediction and stack action
`timescale 1ns/1ps
`include "frontend_defines.svh"

module fetch_seq (
  input logic clk,
  input logic rst,
  input fetch_pkg::addr_t init_ip,
  input retire_pkg::redirect_t redirect,
  input fetch_pkg::fetch_pred_t pred,
  input fetch_pkg::addr_t ras_top,
  output fetch_pkg::addr_t fetch_ip,
  output fetch_pkg::ghr_t fetch_ghr,
  output logic push,
  output logic pop,
  output fetch_pkg::addr_t push_addr,
  output fetch_pkg::fetch_out_t fetch
);

  import fetch_pkg::*;

  addr_t ip_q;
  addr_t ip_nxt;
  ghr_t ghr_q;
  ghr_t ghr_nxt;
  logic valid_q;
  logic ret_taken;
  logic call_taken;

  assign ret_taken = pred.taken && pred.kind == br_ret;
  assign call_taken = pred.taken && pred.kind == br_call;

  always_comb begin
    if (redirect.valid) begin
      ip_nxt = redirect.ip;
      ghr_nxt = redirect.ghr;
    end else begin
      ghr_nxt = {ghr_q[`FE_GHR_W-2:0], pred.taken};
      if (ret_taken) begin
        ip_nxt = ras_top;
      end else if (pred.taken) begin
        ip_nxt = pred.target;
      end else begin
        ip_nxt = next_block(ip_q);
      end
    end
  end

  assign push = valid_q && !redirect.valid && call_taken;
  assign pop = valid_q && !redirect.valid && ret_taken;
  assign push_addr = next_block(ip_q); // fall-through of the call block

  always_ff @(posedge clk) begin
    if (rst) begin
      ip_q <= blk_align(init_ip);
      ghr_q <= '0;
      valid_q <= 1'b0;
    end else if (!valid_q) begin
      valid_q <= 1'b1; // first block shown is init_ip itself
    end else begin
      ip_q <= blk_align(ip_nxt);
      ghr_q <= ghr_nxt;
    end
  end

  assign fetch_ip = ip_q;
  assign fetch_ghr = ghr_q;

  always_comb begin
    fetch.valid = valid_q;
    fetch.ip = ip_q;
    fetch.taken = pred.taken;
  end

endmodule

// ==== logic/fetch_frontend.sv ====
// no back-pressure; retire.valid must only mark mispredicted branches
`timescale 1ns/1ps

module fetch_frontend (
  input logic clk,
  input logic rst,
  input fetch_pkg::addr_t init_ip, // sampled while rst is high
  input retire_pkg::retire_t retire,
  output fetch_pkg::fetch_out_t fetch
);

  import fetch_pkg::*;
  import retire_pkg::*;

  redirect_t redirect;
  btb_update_t btb_upd;
  pt_update_t pt_upd;
  addr_t fetch_ip;
  ghr_t fetch_ghr;
  fetch_pred_t pred;
  logic push;
  logic pop;
  addr_t push_addr;
  addr_t ras_top;

  retire_intake intake_i (
    .clk(clk),
    .rst(rst),
    .retire(retire),
    .redirect(redirect),
    .btb_upd(btb_upd),
    .pt_upd(pt_upd)
  );

  branch_predict bp_i (
    .clk(clk),
    .rst(rst),
    .fetch_ip(fetch_ip),
    .fetch_ghr(fetch_ghr),
    .btb_upd(btb_upd),
    .pt_upd(pt_upd),
    .pred(pred)
  );

  return_stack ras_i (
    .clk(clk),
    .rst(rst),
    .push(push),
    .pop(pop),
    .push_addr(push_addr),
    .top(ras_top)
  );

  fetch_seq seq_i (
    .clk(clk),
    .rst(rst),
    .init_ip(init_ip),
    .redirect(redirect),
    .pred(pred),
    .ras_top(ras_top),
    .fetch_ip(fetch_ip),
    .fetch_ghr(fetch_ghr),
    .push(push),
    .pop(pop),
    .push_addr(push_addr),
    .fetch(fetch)
  );

endmodule

// ==== test/tb_clock.sv ====
// rst is released on a falling edge after rst_cycles rising edges
`timescale 1ns/1ps

module tb_clock #(
  parameter int period_ns = 8,
  parameter int rst_cycles = 16
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (rst_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

// ==== test/frontend_asserts.sv ====
// sampled on the rising edge and silent while rst is high
`timescale 1ns/1ps
`include "frontend_defines.svh"

module frontend_asserts (
  input logic clk,
  input logic rst,
  input logic push,
  input logic pop,
  input fetch_pkg::addr_t fetch_ip,
  input retire_pkg::redirect_t redirect
);

  stack_exclusive: assert property (@(posedge clk) disable iff (rst) !(push && pop))
    else $error("return stack push and pop asserted together");

  ip_aligned: assert property (@(posedge clk) disable iff (rst)
    fetch_ip[`FE_BLOCK_BITS-1:0] == '0)
    else $error("fetch_ip %h is not block aligned", fetch_ip);

  // redirect wins over any stack action
  redirect_quiet: assert property (@(posedge clk) disable iff (rst)
    redirect.valid |-> !push && !pop)
    else $error("stack push or pop in a redirect cycle");

endmodule

bind fetch_seq frontend_asserts asserts_i (
  .clk(clk),
  .rst(rst),
  .push(push),
  .pop(pop),
  .fetch_ip(fetch_ip),
  .redirect(redirect)
);

// ==== test/frontend_tb.sv ====
// retire addresses stay in a 1 KB window at 0x1000; one process drives, models and checks
`timescale 1ns/1ps
`include "frontend_defines.svh"

module frontend_tb;

  import fetch_pkg::*;
  import retire_pkg::*;

  localparam int n_reset = 20;
  localparam int n_jump = 300;
  localparam int n_cond = 300;
  localparam int n_call = 300;
  localparam int n_mix = 2000;
  localparam int max_cycles = 16 + 4 + n_reset + n_jump + n_cond + n_call + n_mix + 50;

  logic clk;
  logic rst;
  addr_t init_ip;
  retire_t retire;
  fetch_out_t fetch;

  integer seed;
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  string test_name;

  // reference model state
  btb_entry_t m_btb [1 << `FE_BTB_IDX_W][`FE_SLOTS];
  logic m_pt [3][1 << `FE_PT_IDX_W][`FE_SLOTS];
  addr_t m_ras [`FE_RAS_DEPTH];
  int m_ras_ptr;
  addr_t m_ip;
  ghr_t m_ghr;
  int m_sel; // 0 = A, 1 = B, 2 = C
  retire_t m_rq; // retire held inside the DUT
  logic p_taken;
  br_kind_t p_kind;
  addr_t p_target;

  tb_clock #(.period_ns(8), .rst_cycles(16)) clk_i (.clk(clk), .rst(rst));

  fetch_frontend dut_i (
    .clk(clk),
    .rst(rst),
    .init_ip(init_ip),
    .retire(retire),
    .fetch(fetch)
  );

  function automatic addr_t align16(input addr_t a);
    return {a[`FE_ADDR_W-1:4], 4'b0000};
  endfunction

  function automatic int tbl_idx(input int t, input addr_t a, input ghr_t g);
    case (t)
      0: return int'({a[9:4], g[1:0]});
      1: return int'({a[7:4], g[3:0]});
      default: return int'(g);
    endcase
  endfunction

  task automatic predict();
    int bi;
    logic dir;
    p_taken = 1'b0;
    p_kind = br_cond;
    p_target = '0;
    bi = int'(m_ip[12:4]);
    for (int s = 0; s < `FE_SLOTS; s++) begin // first taken slot wins
      dir = m_pt[0][tbl_idx(0, m_ip, m_ghr)][s] ^ m_pt[1][tbl_idx(1, m_ip, m_ghr)][s] ^
            m_pt[2][tbl_idx(2, m_ip, m_ghr)][s];
      if (!p_taken && m_btb[bi][s].valid && m_btb[bi][s].tag == m_ip[42:13] &&
          (m_btb[bi][s].kind != br_cond || dir)) begin
        p_taken = 1'b1;
        p_kind = m_btb[bi][s].kind;
        p_target = m_btb[bi][s].target;
      end
    end
  endtask

  // state after the coming rising edge
  task automatic model_step(input retire_t r);
    addr_t nxt;
    ghr_t g_nxt;
    int t;
    if (m_rq.valid) begin
      nxt = m_rq.taken ? m_rq.target : align16(m_rq.src_ip) + addr_t'(16);
      g_nxt = {m_rq.ghr[6:0], m_rq.taken};
    end else begin
      g_nxt = {m_ghr[6:0], p_taken};
      if (p_taken && p_kind == br_ret) begin
        nxt = m_ras[(m_ras_ptr + `FE_RAS_DEPTH - 1) % `FE_RAS_DEPTH];
        m_ras_ptr = (m_ras_ptr + `FE_RAS_DEPTH - 1) % `FE_RAS_DEPTH;
      end else if (p_taken) begin
        nxt = p_target;
        if (p_kind == br_call) begin
          m_ras[m_ras_ptr] = align16(m_ip) + addr_t'(16);
          m_ras_ptr = (m_ras_ptr + 1) % `FE_RAS_DEPTH;
        end
      end else begin
        nxt = align16(m_ip) + addr_t'(16);
      end
    end
    if (m_rq.valid) begin
      m_btb[int'(m_rq.src_ip[12:4])][m_rq.slot] = '{valid: 1'b1, tag: m_rq.src_ip[42:13],
                                                     target: m_rq.target, kind: m_rq.kind};
      if (m_rq.kind == br_cond) begin
        t = m_sel;
        m_pt[t][tbl_idx(t, m_rq.src_ip, m_rq.ghr)][m_rq.slot] =
          !m_pt[t][tbl_idx(t, m_rq.src_ip, m_rq.ghr)][m_rq.slot];
        m_sel = (m_sel + 1) % 3;
      end
    end
    m_ip = align16(nxt);
    m_ghr = g_nxt;
    m_rq = r;
  endtask

  // mode 0 idle, 1 jump, 2 cond, 3 call or ret, 4 any kind
  task automatic make_retire(input int mode, output retire_t r);
    logic [1:0] pick;
    r = '0;
    if (mode == 0 || ($random(seed) & 7) != 0) return; // about one cycle in eight
    pick = 2'($random(seed));
    r.valid = 1'b1;
    r.src_ip = addr_t'(32'h1000 + (($random(seed) & 32'h3f) << 4) + ($random(seed) & 15));
    r.target = addr_t'(32'h1000 + ($random(seed) & 32'h3ff));
    r.slot = slot_t'($random(seed));
    case (mode)
      1: r.kind = br_jump;
      2: r.kind = br_cond;
      3: r.kind = pick[0] ? br_call : br_ret;
      default: r.kind = br_kind_t'(pick);
    endcase
    r.taken = (r.kind == br_cond) ? 1'($random(seed)) : 1'b1;
    r.ghr = ghr_t'($random(seed));
  endtask

  task automatic check_fetch();
    checks++;
    assert (fetch.valid) else begin
      errors++;
      $display("** Error [%s] fetch.valid expected 1, actual %b", test_name, fetch.valid);
    end
    assert (fetch.ip == m_ip) else begin
      errors++;
      $display("** Error [%s] fetch.ip expected %h, actual %h", test_name, m_ip, fetch.ip);
    end
    assert (fetch.taken == p_taken) else begin
      errors++;
      $display("** Error [%s] fetch.taken expected %b, actual %b", test_name, p_taken,
               fetch.taken);
    end
  endtask

  // starts and ends on a falling edge
  task automatic run_phase(input string name, input int mode, input int n);
    retire_t r;
    test_name = name;
    repeat (n) begin
      predict();
      check_fetch();
      make_retire(mode, r);
      retire = r;
      model_step(r);
      @(negedge clk);
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    seed = 77208;
    init_ip = addr_t'(32'h1007);
    retire = '0;
    for (int i = 0; i < (1 << `FE_BTB_IDX_W); i++) begin
      for (int s = 0; s < `FE_SLOTS; s++) begin
        m_btb[i][s] = '0;
      end
    end
    for (int t = 0; t < 3; t++) begin
      for (int i = 0; i < (1 << `FE_PT_IDX_W); i++) begin
        for (int s = 0; s < `FE_SLOTS; s++) begin
          m_pt[t][i][s] = 1'b0;
        end
      end
    end
    for (int i = 0; i < `FE_RAS_DEPTH; i++) begin
      m_ras[i] = '0;
    end
    m_ras_ptr = 0;
    m_ip = align16(init_ip);
    m_ghr = '0;
    m_sel = 0;
    m_rq = '0;
    test_name = "reset";

    @(negedge clk);
    assert (!fetch.valid) else begin
      errors++;
      $display("** Error [%s] fetch.valid during reset expected 0, actual %b", test_name,
               fetch.valid);
    end
    while (rst) @(negedge clk);
    while (!fetch.valid) @(negedge clk);

    run_phase("reset", 0, n_reset);
    run_phase("jump", 1, n_jump);
    run_phase("cond", 2, n_cond);
    run_phase("call_ret", 3, n_call);
    run_phase("mix", 4, n_mix);
    predict();
    check_fetch();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== fetch_frontend.f ====
+incdir+logic
logic/fetch_pkg.sv
logic/retire_pkg.sv
logic/entry_ram.sv
logic/retire_intake.sv
logic/branch_predict.sv
logic/return_stack.sv
logic/fetch_seq.sv
logic/fetch_frontend.sv
test/tb_clock.sv
test/frontend_asserts.sv
test/frontend_tb.sv

// ==== Makefile ====
# Verilator simulation of the fetch front end
VERILATOR ?= verilator
TOP ?= frontend_tb
FLIST ?= fetch_frontend.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
FAIL_MSG ?= Simulation FAILED

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q -e "$(FAIL_MSG)" -e "%Error" $(LOG); then \
	  echo "sim: failures found, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

.PHONY: sim clean
